// ==== design/ad7616_pkg.sv ====
// shared types and constants for the ad7616 parallel capture path
// referenced by scoped name from the engine, buffer, framer and testbench

package ad7616_pkg;

  // ****************************************
  // bus and strobe sizing
  // ****************************************

  // adc data bus and sample width
  localparam int data_width = 16;
  // cycles per strobe phase, low or high
  localparam int strobe_cycles = 4;
  localparam int width_cnt_bits = $clog2(strobe_cycles);
  // last count value of a strobe phase
  localparam logic [width_cnt_bits-1:0] strobe_last = width_cnt_bits'(strobe_cycles - 1);
  // burst length and pair index
  localparam int burst_width = 5;

  // sample buffer geometry
  localparam int buffer_depth = 8;
  localparam int buffer_addr_width = $clog2(buffer_depth);
  localparam int buffer_count_width = $clog2(buffer_depth + 1);

  // ****************************************
  // payload types
  // ****************************************

  // engine -> buffer -> framer
  typedef struct packed {
    logic                  sync;
    logic [data_width-1:0] data;
  } sample_t;

  // one a/b pair, tagged
  typedef struct packed {
    logic                   sync;
    logic [burst_width-1:0] index;
    logic [data_width-1:0]  chan_b;
    logic [data_width-1:0]  chan_a;
  } frame_t;

  // transfer kind, latched by the engine while idle
  typedef enum logic [1:0] {xfer_conv, xfer_reg_rd, xfer_reg_wr} xfer_kind_t;

  // bus engine states
  typedef enum logic [2:0] {
    idle, cs_low, ctl0_low, ctl0_high, ctl1_low, ctl1_high, cs_high
  } bus_state_t;

endpackage

// ==== design/ad7616_bus_engine.sv ====
// parallel bus engine for the ad7616
// times cs_n, rd_n and wr_n, drives the data bus tristate and captures db_i
// conversion reads push samples, register reads return on rd_data/rd_valid

`timescale 1ns/1ps

module ad7616_bus_engine (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  end_of_conv,
  input  logic                                  rd_req,
  input  logic                                  wr_req,
  input  logic [ad7616_pkg::data_width-1:0]     wr_data,
  input  logic [ad7616_pkg::burst_width-1:0]    burst_length,
  input  logic [ad7616_pkg::data_width-1:0]     db_i,
  output logic                                  cs_n,
  output logic                                  rd_n,
  output logic                                  wr_n,
  output logic                                  db_t,
  output logic [ad7616_pkg::data_width-1:0]     db_o,
  output logic                                  push,
  output ad7616_pkg::sample_t                   push_sample,
  output logic [ad7616_pkg::data_width-1:0]     rd_data,
  output logic                                  rd_valid
);

  ad7616_pkg::bus_state_t                 state_q;
  ad7616_pkg::bus_state_t                 state_d;
  ad7616_pkg::xfer_kind_t                 kind_q;
  logic [ad7616_pkg::width_cnt_bits-1:0]  width_cnt;
  logic [ad7616_pkg::burst_width-1:0]     burst_cnt;
  logic [ad7616_pkg::data_width-1:0]      wr_data_q;
  ad7616_pkg::sample_t                    sample_q;
  logic                                   first_q;
  logic                                   start;
  logic                                   in_ctl;
  logic                                   phase_done;
  logic                                   capture;

  assign start = end_of_conv | rd_req | wr_req;
  assign in_ctl = (state_q == ad7616_pkg::ctl0_low) || (state_q == ad7616_pkg::ctl0_high) ||
                  (state_q == ad7616_pkg::ctl1_low) || (state_q == ad7616_pkg::ctl1_high);
  assign phase_done = (width_cnt == ad7616_pkg::strobe_last);

  // ****************************************
  // state machine
  // ****************************************

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state_q <= ad7616_pkg::idle;
    end else begin
      state_q <= state_d;
    end
  end

  always_comb begin
    state_d = state_q;
    case (state_q)
      ad7616_pkg::idle: begin
        if (start) state_d = ad7616_pkg::cs_low;
      end
      ad7616_pkg::cs_low: state_d = ad7616_pkg::ctl0_low;
      ad7616_pkg::ctl0_low: begin
        if (phase_done) state_d = ad7616_pkg::ctl0_high;
      end
      ad7616_pkg::ctl0_high: begin
        // register access ends after the first strobe
        if (phase_done) begin
          state_d = (kind_q == ad7616_pkg::xfer_conv) ? ad7616_pkg::ctl1_low
                                                       : ad7616_pkg::cs_high;
        end
      end
      ad7616_pkg::ctl1_low: begin
        if (phase_done) state_d = ad7616_pkg::ctl1_high;
      end
      ad7616_pkg::ctl1_high: begin
        if (phase_done) state_d = ad7616_pkg::cs_high;
      end
      ad7616_pkg::cs_high: begin
        if ((kind_q != ad7616_pkg::xfer_conv) || (burst_cnt == burst_length)) begin
          state_d = ad7616_pkg::idle;
        end else begin
          state_d = ad7616_pkg::ctl0_low;
        end
      end
      default: state_d = ad7616_pkg::idle;
    endcase
  end

  // strobe phase width, wraps into the next phase
  always_ff @(posedge clk) begin
    if (!rstn || !in_ctl) begin
      width_cnt <= '0;
    end else begin
      width_cnt <= width_cnt + 1'b1;
    end
  end

  // pair counter, one step per cs_high
  always_ff @(posedge clk) begin
    if (!rstn || (state_q == ad7616_pkg::idle)) begin
      burst_cnt <= '0;
    end else if (state_q == ad7616_pkg::cs_high) begin
      burst_cnt <= burst_cnt + 1'b1;
    end
  end

  // request latch, conversion has priority
  always_ff @(posedge clk) begin
    if (!rstn) begin
      kind_q <= ad7616_pkg::xfer_conv;
      first_q <= 1'b0;
    end else if (state_q == ad7616_pkg::idle) begin
      if (end_of_conv) begin
        kind_q <= ad7616_pkg::xfer_conv;
        first_q <= 1'b1;
      end else if (rd_req) begin
        kind_q <= ad7616_pkg::xfer_reg_rd;
      end else if (wr_req) begin
        kind_q <= ad7616_pkg::xfer_reg_wr;
      end
    end else if (capture) begin
      // only the first sample of a burst is tagged
      first_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if ((state_q == ad7616_pkg::idle) && wr_req) begin
      wr_data_q <= wr_data;
    end
  end

  // ****************************************
  // data capture
  // ****************************************

  // first cycle of a high phase after a read strobe
  assign capture = ((state_q == ad7616_pkg::ctl0_high) || (state_q == ad7616_pkg::ctl1_high)) &&
                   (width_cnt == '0) && (kind_q != ad7616_pkg::xfer_reg_wr);

  always_ff @(posedge clk) begin
    if (capture) begin
      sample_q.data <= db_i;
      sample_q.sync <= first_q & (kind_q == ad7616_pkg::xfer_conv);
    end
  end

  // strobes land one cycle after the capture cycle
  always_ff @(posedge clk) begin
    if (!rstn) begin
      push <= 1'b0;
      rd_valid <= 1'b0;
    end else begin
      push <= capture & (kind_q == ad7616_pkg::xfer_conv);
      rd_valid <= capture & (kind_q == ad7616_pkg::xfer_reg_rd);
    end
  end

  assign push_sample = sample_q;
  assign rd_data = sample_q.data;

  // ****************************************
  // bus outputs
  // ****************************************

  assign cs_n = (state_q == ad7616_pkg::idle);
  assign rd_n = !(((state_q == ad7616_pkg::ctl0_low) && (kind_q != ad7616_pkg::xfer_reg_wr)) ||
                  (state_q == ad7616_pkg::ctl1_low));
  assign wr_n = !((state_q == ad7616_pkg::ctl0_low) && (kind_q == ad7616_pkg::xfer_reg_wr));
  // bus driven only for a register write
  assign db_t = !((state_q != ad7616_pkg::idle) && (kind_q == ad7616_pkg::xfer_reg_wr));
  assign db_o = wr_data_q;

  // strobes never overlap and stay inside chip select
  assert property (@(posedge clk) disable iff (!rstn) !(!rd_n && !wr_n));
  assert property (@(posedge clk) disable iff (!rstn) (!rd_n || !wr_n) |-> !cs_n);
  // register accesses stay off the sample path
  assert property (@(posedge clk) disable iff (!rstn) push |-> (kind_q == ad7616_pkg::xfer_conv));

endmodule

// ==== design/sample_buffer.sv ====
// small circular fifo between the bus engine and the framer
// payload type is a parameter, head shows the oldest entry while not empty

`timescale 1ns/1ps

module sample_buffer #(
  parameter type payload_t = ad7616_pkg::sample_t
) (
  input  logic     clk,
  input  logic     rstn,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output payload_t head,
  output logic     empty
);

  // ****************************************
  // storage and pointers
  // ****************************************

  payload_t                                     mem [ad7616_pkg::buffer_depth];
  logic [ad7616_pkg::buffer_addr_width-1:0]     wr_ptr;
  logic [ad7616_pkg::buffer_addr_width-1:0]     rd_ptr;
  logic [ad7616_pkg::buffer_count_width-1:0]    count;
  logic                                         full;

  assign empty = (count == '0);
  assign full = (count == ad7616_pkg::buffer_depth);

  // entry write
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  // pointers wrap on the power of two depth
  always_ff @(posedge clk) begin
    if (!rstn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // occupancy
  always_ff @(posedge clk) begin
    if (!rstn) begin
      count <= '0;
    end else begin
      case ({push, pop})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // oldest entry, valid while not empty
  assign head = mem[rd_ptr];

  // ****************************************
  // checks
  // ****************************************

  // the consumer drains faster than the engine fills
  assert property (@(posedge clk) disable iff (!rstn) push |-> !full);
  assert property (@(posedge clk) disable iff (!rstn) pop |-> !empty);

endmodule

// ==== design/sample_framer.sv ====
// joins channel a and channel b samples into tagged frame words
// pops every cycle the buffer holds data, frame_valid is a one-cycle strobe
// index restarts on a synced sample and counts pairs within a burst

`timescale 1ns/1ps

module sample_framer (
  input  logic                clk,
  input  logic                rstn,
  input  logic                empty,
  input  ad7616_pkg::sample_t head,
  output logic                pop,
  output logic                frame_valid,
  output ad7616_pkg::frame_t  frame
);

  logic                                    have_a;
  ad7616_pkg::sample_t                     chan_a_q;
  logic [ad7616_pkg::burst_width-1:0]      pair_idx;

  // drain whenever something is queued
  assign pop = !empty;

  // ****************************************
  // a/b pairing
  // ****************************************

  // toggles between waiting for a and waiting for b
  always_ff @(posedge clk) begin
    if (!rstn) begin
      have_a <= 1'b0;
    end else if (pop) begin
      have_a <= !have_a;
    end
  end

  // hold channel a until its partner arrives
  always_ff @(posedge clk) begin
    if (pop && !have_a) begin
      chan_a_q <= head;
    end
  end

  // pair index of the frame being assembled
  always_ff @(posedge clk) begin
    if (!rstn) begin
      pair_idx <= '0;
    end else if (pop) begin
      if (!have_a && head.sync) begin
        // new burst
        pair_idx <= '0;
      end else if (have_a) begin
        pair_idx <= pair_idx + 1'b1;
      end
    end
  end

  // ****************************************
  // frame output
  // ****************************************

  // valid one cycle after the channel b pop
  always_ff @(posedge clk) begin
    if (!rstn) begin
      frame_valid <= 1'b0;
    end else begin
      frame_valid <= pop & have_a;
    end
  end

  always_ff @(posedge clk) begin
    if (pop && have_a) begin
      frame.sync <= chan_a_q.sync;
      frame.index <= pair_idx;
      frame.chan_a <= chan_a_q.data;
      frame.chan_b <= head.data;
    end
  end

  // engine tags only the first sample of a burst, which is always channel a
  assert property (@(posedge clk) disable iff (!rstn) (pop && have_a) |-> !head.sync);

endmodule

// ==== design/ad7616_capture_top.sv ====
// capture subsystem top for the ad7616 parallel interface
// bus engine -> sample buffer -> framer, register reads bypass the buffer
// brings out the adc bus, the register port and the frame strobe

`timescale 1ns/1ps

module ad7616_capture_top (
  input  logic                                  clk,
  input  logic                                  rstn,
  input  logic                                  end_of_conv,
  input  logic [ad7616_pkg::burst_width-1:0]    burst_length,
  input  logic                                  rd_req,
  input  logic                                  wr_req,
  input  logic [ad7616_pkg::data_width-1:0]     wr_data,
  input  logic [ad7616_pkg::data_width-1:0]     db_i,
  output logic                                  cs_n,
  output logic                                  rd_n,
  output logic                                  wr_n,
  output logic                                  db_t,
  output logic [ad7616_pkg::data_width-1:0]     db_o,
  output logic [ad7616_pkg::data_width-1:0]     rd_data,
  output logic                                  rd_valid,
  output logic                                  frame_valid,
  output ad7616_pkg::frame_t                    frame
);

  // ****************************************
  // internal links
  // ****************************************

  // engine to buffer
  logic                push;
  ad7616_pkg::sample_t push_sample;
  // buffer to framer
  logic                pop;
  logic                empty;
  ad7616_pkg::sample_t head;

  ad7616_bus_engine u_engine (
    .clk          (clk),
    .rstn         (rstn),
    .end_of_conv  (end_of_conv),
    .rd_req       (rd_req),
    .wr_req       (wr_req),
    .wr_data      (wr_data),
    .burst_length (burst_length),
    .db_i         (db_i),
    .cs_n         (cs_n),
    .rd_n         (rd_n),
    .wr_n         (wr_n),
    .db_t         (db_t),
    .db_o         (db_o),
    .push         (push),
    .push_sample  (push_sample),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid)
  );

  sample_buffer #(
    .payload_t (ad7616_pkg::sample_t)
  ) u_buffer (
    .clk       (clk),
    .rstn      (rstn),
    .push      (push),
    .push_data (push_sample),
    .pop       (pop),
    .head      (head),
    .empty     (empty)
  );

  sample_framer u_framer (
    .clk         (clk),
    .rstn        (rstn),
    .empty       (empty),
    .head        (head),
    .pop         (pop),
    .frame_valid (frame_valid),
    .frame       (frame)
  );

endmodule

// ==== verification/tb_clock_gen.sv ====
// clock and reset source for the capture testbench
// 100 ns clock, active-low reset held for the first 4 rising edges

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk,
  output logic rstn
);

  // 50 ns half period
  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  initial begin
    rstn = 1'b0;
    repeat (4) @(posedge clk);
    rstn <= 1'b1;
  end

endmodule

// ==== verification/adc_bus_model.sv ====
// behavioral ad7616 on the parallel bus
// conversion reads return base plus a read count that restarts on end_of_conv
// register reads return the word latched on the last rising edge of wr_n

`timescale 1ns/1ps

module adc_bus_model (
  input  logic                              clk,
  input  logic                              rstn,
  input  logic                              end_of_conv,
  input  logic [ad7616_pkg::data_width-1:0] base,
  input  logic                              cs_n,
  input  logic                              rd_n,
  input  logic                              wr_n,
  input  logic [ad7616_pkg::data_width-1:0] db_o,
  output logic [ad7616_pkg::data_width-1:0] db_i
);

  logic [ad7616_pkg::data_width-1:0] read_cnt;
  logic [ad7616_pkg::data_width-1:0] reg_q;
  // set from end_of_conv until chip select rises again
  logic                              conv_active;
  logic                              rd_n_q;
  logic                              wr_n_q;
  logic                              cs_n_q;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      db_i <= '0;
      read_cnt <= '0;
      reg_q <= '0;
      conv_active <= 1'b0;
      rd_n_q <= 1'b1;
      wr_n_q <= 1'b1;
      cs_n_q <= 1'b1;
    end else begin
      rd_n_q <= rd_n;
      wr_n_q <= wr_n;
      cs_n_q <= cs_n;
      // a new conversion only while the bus is idle
      if (end_of_conv && cs_n) begin
        conv_active <= 1'b1;
        read_cnt <= '0;
      end else if (cs_n && !cs_n_q) begin
        conv_active <= 1'b0;
      end
      // answer on the falling edge of rd_n
      if (!rd_n && rd_n_q) begin
        if (conv_active) begin
          db_i <= base + read_cnt;
          read_cnt <= read_cnt + 1'b1;
        end else begin
          db_i <= reg_q;
        end
      end
      // register write lands when wr_n rises
      if (wr_n && !wr_n_q) begin
        reg_q <= db_o;
      end
    end
  end

endmodule

// ==== verification/tb_ad7616_capture.sv ====
// testbench for the ad7616 capture top level
// applies a table of conversion and register transfers against a bus model
// frames and register reads are checked against values built from the row

`timescale 1ns/1ps

module tb_ad7616_capture;

  localparam int num_rows = 8;
  localparam int wait_limit = 2000;
  // events that the wait loop can look for
  localparam int ev_reset = 0;
  localparam int ev_frame = 1;
  localparam int ev_rd_valid = 2;
  localparam int ev_busy = 3;
  localparam int ev_idle = 4;

  // one stimulus row with its expected register read word
  typedef struct packed {
    ad7616_pkg::xfer_kind_t                kind;
    logic [ad7616_pkg::burst_width-1:0]    burst_length;
    logic [ad7616_pkg::data_width-1:0]     wr_data;
    logic [ad7616_pkg::data_width-1:0]     exp_rd;
  } row_t;

  logic                                  clk;
  logic                                  rstn;
  logic                                  end_of_conv;
  logic                                  rd_req;
  logic                                  wr_req;
  logic [ad7616_pkg::data_width-1:0]     wr_data;
  logic [ad7616_pkg::burst_width-1:0]    burst_length;
  logic [ad7616_pkg::data_width-1:0]     base;
  logic [ad7616_pkg::data_width-1:0]     db_i;
  logic [ad7616_pkg::data_width-1:0]     db_o;
  logic [ad7616_pkg::data_width-1:0]     rd_data;
  logic                                  cs_n;
  logic                                  rd_n;
  logic                                  wr_n;
  logic                                  db_t;
  logic                                  rd_valid;
  logic                                  frame_valid;
  ad7616_pkg::frame_t                    frame;

  row_t rows [num_rows];
  int   errors = 0;
  int   checks = 0;
  // running totals kept by the monitor
  int   frame_total = 0;
  int   rd_valid_total = 0;
  int   overlap_total = 0;

  tb_clock_gen u_clock (
    .clk  (clk),
    .rstn (rstn)
  );

  adc_bus_model u_adc (
    .clk         (clk),
    .rstn        (rstn),
    .end_of_conv (end_of_conv),
    .base        (base),
    .cs_n        (cs_n),
    .rd_n        (rd_n),
    .wr_n        (wr_n),
    .db_o        (db_o),
    .db_i        (db_i)
  );

  ad7616_capture_top uut (
    .clk          (clk),
    .rstn         (rstn),
    .end_of_conv  (end_of_conv),
    .burst_length (burst_length),
    .rd_req       (rd_req),
    .wr_req       (wr_req),
    .wr_data      (wr_data),
    .db_i         (db_i),
    .cs_n         (cs_n),
    .rd_n         (rd_n),
    .wr_n         (wr_n),
    .db_t         (db_t),
    .db_o         (db_o),
    .rd_data      (rd_data),
    .rd_valid     (rd_valid),
    .frame_valid  (frame_valid),
    .frame        (frame)
  );

  // ****************************************
  // monitor, sampled mid-cycle
  // ****************************************

  always @(negedge clk) begin
    if (rstn === 1'b1) begin
      if (frame_valid === 1'b1) frame_total++;
      if (rd_valid === 1'b1) rd_valid_total++;
      if (rd_n === 1'b0 && wr_n === 1'b0) overlap_total++;
    end
  end

  // ****************************************
  // stimulus table
  // ****************************************

  task automatic load_table();
    rows[0] = '{ad7616_pkg::xfer_conv, 5'd0, 16'h0000, 16'h0000};
    rows[1] = '{ad7616_pkg::xfer_conv, 5'd3, 16'h0000, 16'h0000};
    rows[2] = '{ad7616_pkg::xfer_reg_wr, 5'd0, 16'ha5c3, 16'h0000};
    rows[3] = '{ad7616_pkg::xfer_reg_rd, 5'd0, 16'h0000, 16'ha5c3};
    // back to back bursts
    rows[4] = '{ad7616_pkg::xfer_conv, 5'd2, 16'h0000, 16'h0000};
    rows[5] = '{ad7616_pkg::xfer_conv, 5'd1, 16'h0000, 16'h0000};
    rows[6] = '{ad7616_pkg::xfer_reg_wr, 5'd0, 16'h3c96, 16'h0000};
    rows[7] = '{ad7616_pkg::xfer_reg_rd, 5'd0, 16'h0000, 16'h3c96};
  endtask

  function automatic string kind_text(input ad7616_pkg::xfer_kind_t kind);
    case (kind)
      ad7616_pkg::xfer_conv: return "conversion";
      ad7616_pkg::xfer_reg_rd: return "register read";
      ad7616_pkg::xfer_reg_wr: return "register write";
      default: return "unknown";
    endcase
  endfunction

  // ****************************************
  // compare tasks
  // ****************************************

  task automatic check_frame(input ad7616_pkg::frame_t got, input ad7616_pkg::frame_t exp,
                             input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got sync %0b index %0d a %h b %h, expected %0b %0d %h %h",
               $time, what, got.sync, got.index, got.chan_a, got.chan_b,
               exp.sync, exp.index, exp.chan_a, exp.chan_b);
    end
  endtask

  task automatic check_reg(input logic [ad7616_pkg::data_width-1:0] got,
                           input logic [ad7616_pkg::data_width-1:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_level(input logic got, input logic exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp);
    end
  endtask

  // ****************************************
  // bounded waits
  // ****************************************

  function automatic bit event_seen(input int sel);
    case (sel)
      ev_reset: return rstn === 1'b1;
      ev_frame: return frame_valid === 1'b1;
      ev_rd_valid: return rd_valid === 1'b1;
      ev_busy: return cs_n === 1'b0;
      default: return cs_n === 1'b1;
    endcase
  endfunction

  task automatic wait_for_event(input int sel, input string what, output bit ok);
    int cycles;
    ok = 1'b0;
    cycles = 0;
    while (!ok && cycles < wait_limit) begin
      @(negedge clk);
      ok = event_seen(sel);
      cycles++;
    end
    if (!ok) begin
      errors++;
      $display("timeout: %s did not happen within %0d cycles at %0t", what, wait_limit, $time);
    end
  endtask

  // one table row, from request pulse back to an idle bus
  task automatic apply_row(input int idx);
    row_t                                r;
    logic [ad7616_pkg::data_width-1:0]   row_base;
    ad7616_pkg::frame_t                  exp;
    bit                                  ok;
    bit                                  is_conv;
    int                                  frames_at_start;
    int                                  rd_at_start;
    int                                  overlap_at_start;
    r = rows[idx];
    is_conv = (r.kind == ad7616_pkg::xfer_conv);
    row_base = 16'($urandom);
    frames_at_start = frame_total;
    rd_at_start = rd_valid_total;
    overlap_at_start = overlap_total;
    @(posedge clk);
    base <= row_base;
    burst_length <= r.burst_length;
    wr_data <= r.wr_data;
    end_of_conv <= is_conv;
    rd_req <= (r.kind == ad7616_pkg::xfer_reg_rd);
    wr_req <= (r.kind == ad7616_pkg::xfer_reg_wr);
    @(posedge clk);
    end_of_conv <= 1'b0;
    rd_req <= 1'b0;
    wr_req <= 1'b0;
    wait_for_event(ev_busy, "bus start", ok);
    // bus is driven only by a register write
    check_level(db_t, (r.kind == ad7616_pkg::xfer_reg_wr) ? 1'b0 : 1'b1, "db_t while busy");
    if (is_conv) begin
      for (int k = 0; k <= int'(r.burst_length) && ok; k++) begin
        wait_for_event(ev_frame, "frame_valid", ok);
        if (ok) begin
          exp.sync = (k == 0);
          exp.index = 5'(k);
          exp.chan_a = row_base + 16'(2 * k);
          exp.chan_b = row_base + 16'(2 * k + 1);
          check_frame(frame, exp, $sformatf("frame %0d", k));
        end
      end
    end else if (r.kind == ad7616_pkg::xfer_reg_rd) begin
      wait_for_event(ev_rd_valid, "rd_valid", ok);
      if (ok) check_reg(rd_data, r.exp_rd, "register read data");
    end
    wait_for_event(ev_idle, "return to idle", ok);
    check_count(frame_total - frames_at_start, is_conv ? int'(r.burst_length) + 1 : 0,
                "frames in row");
    check_count(rd_valid_total - rd_at_start, (r.kind == ad7616_pkg::xfer_reg_rd) ? 1 : 0,
                "rd_valid strobes in row");
    check_count(overlap_total - overlap_at_start, 0, "cycles with rd_n and wr_n both low");
  endtask

  // ****************************************
  // main sequence
  // ****************************************

  initial begin
    int idx;
    int errors_before;
    int expected_frames;
    bit ok;
    end_of_conv = 1'b0;
    rd_req = 1'b0;
    wr_req = 1'b0;
    wr_data = '0;
    burst_length = '0;
    base = '0;
    expected_frames = 0;
    void'($urandom(32'h5c9f));
    load_table();
    wait_for_event(ev_reset, "reset release", ok);

    // idle bus after reset
    errors_before = errors;
    repeat (8) begin
      @(negedge clk);
      check_level(cs_n, 1'b1, "cs_n idle");
      check_level(rd_n, 1'b1, "rd_n idle");
      check_level(wr_n, 1'b1, "wr_n idle");
      check_level(db_t, 1'b1, "db_t idle");
      check_level(frame_valid, 1'b0, "frame_valid idle");
      check_level(rd_valid, 1'b0, "rd_valid idle");
    end
    $display("test 0 reset idle: %s", (errors == errors_before) ? "ok" : "failed");

    for (idx = 0; idx < num_rows; idx++) begin
      errors_before = errors;
      apply_row(idx);
      if (rows[idx].kind == ad7616_pkg::xfer_conv) begin
        expected_frames += int'(rows[idx].burst_length) + 1;
      end
      $display("test %0d %s burst %0d: %s", idx + 1, kind_text(rows[idx].kind),
               rows[idx].burst_length, (errors == errors_before) ? "ok" : "failed");
    end
    check_count(frame_total, expected_frames, "total frames");

    $display("checks %0d, errors %0d, frames %0d", checks, errors, frame_total);
    if (errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

// ==== build.f ====
design/ad7616_pkg.sv
design/ad7616_bus_engine.sv
design/sample_buffer.sv
design/sample_framer.sv
design/ad7616_capture_top.sv
verification/tb_clock_gen.sv
verification/adc_bus_model.sv
verification/tb_ad7616_capture.sv

// ==== Bender.yml ====
package:
  name: ad7616_capture

sources:
  # design
  - files:
      - design/ad7616_pkg.sv
      - design/ad7616_bus_engine.sv
      - design/sample_buffer.sv
      - design/sample_framer.sv
      - design/ad7616_capture_top.sv
  # verification
  - target: test
    files:
      - verification/tb_clock_gen.sv
      - verification/adc_bus_model.sv
      - verification/tb_ad7616_capture.sv
